//--- design/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::decoded_t   dec_i,
    output core_pkg::executed_t  exe_o
);

    logic [2*core_pkg::xlen-1:0] product;
    logic                        less_signed;
    core_pkg::executed_t         exe_d;
    core_pkg::executed_t         exe_q;

    // full 64-bit unsigned product
    assign product = {{core_pkg::xlen{1'b0}}, dec_i.src_a}
                   * {{core_pkg::xlen{1'b0}}, dec_i.src_b};

    // slt compare
    assign less_signed = $signed(dec_i.src_a) < $signed(dec_i.src_b);

    always_comb begin
        exe_d.valid      = dec_i.valid;
        exe_d.op         = dec_i.op;
        exe_d.rd         = dec_i.rd;
        exe_d.value      = '0;
        exe_d.product_hi = '0;
        case (dec_i.op)
            // wrapping add / sub
            core_pkg::op_addu, core_pkg::op_addiu: begin
                exe_d.value = dec_i.src_a + dec_i.src_b;
            end
            core_pkg::op_subu: exe_d.value = dec_i.src_a - dec_i.src_b;
            core_pkg::op_and:  exe_d.value = dec_i.src_a & dec_i.src_b;
            core_pkg::op_or, core_pkg::op_ori: begin
                exe_d.value = dec_i.src_a | dec_i.src_b;
            end
            core_pkg::op_xor:  exe_d.value = dec_i.src_a ^ dec_i.src_b;
            core_pkg::op_slt: begin
                exe_d.value = {{(core_pkg::xlen-1){1'b0}}, less_signed};
            end
            // shifts act on rt
            core_pkg::op_sll:  exe_d.value = dec_i.src_b << dec_i.shamt;
            core_pkg::op_srl:  exe_d.value = dec_i.src_b >> dec_i.shamt;
            // immediate already in upper half
            core_pkg::op_lui:  exe_d.value = dec_i.src_b;
            core_pkg::op_multu: begin
                exe_d.value      = product[core_pkg::xlen-1:0];
                exe_d.product_hi = product[2*core_pkg::xlen-1:core_pkg::xlen];
            end
            // mfhi/mflo resolved in result stage
            default: ;
        endcase
    end

    // fixed one-cycle stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            exe_q.valid <= 1'b0;
        end else begin
            exe_q <= exe_d;
        end
    end

    assign exe_o = exe_q;

endmodule

//--- design/core_pkg.sv
package core_pkg;

    // datapath and register file sizing
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    localparam int imm_w      = 16;

    // primary opcode field, instr[31:26]
    localparam logic [5:0] opc_special = 6'h00;
    localparam logic [5:0] opc_addiu   = 6'h09;
    localparam logic [5:0] opc_ori     = 6'h0d;
    localparam logic [5:0] opc_lui     = 6'h0f;

    // function field of special, instr[5:0]
    localparam logic [5:0] fn_sll   = 6'h00;
    localparam logic [5:0] fn_srl   = 6'h02;
    localparam logic [5:0] fn_mfhi  = 6'h10;
    localparam logic [5:0] fn_mflo  = 6'h12;
    localparam logic [5:0] fn_multu = 6'h19;
    localparam logic [5:0] fn_addu  = 6'h21;
    localparam logic [5:0] fn_subu  = 6'h23;
    localparam logic [5:0] fn_and   = 6'h24;
    localparam logic [5:0] fn_or    = 6'h25;
    localparam logic [5:0] fn_xor   = 6'h26;
    localparam logic [5:0] fn_slt   = 6'h2a;

    // internal operation code, op_nop for anything not decoded
    typedef enum logic [3:0] {
        op_nop, op_addu, op_subu, op_and, op_or, op_xor, op_slt, op_sll,
        op_srl, op_addiu, op_ori, op_lui, op_multu, op_mfhi, op_mflo
    } opcode_t;

    // decode -> execute
    typedef struct packed {
        logic                  valid;
        opcode_t               op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       src_a;
        logic [xlen-1:0]       src_b;
        logic [4:0]            shamt;
    } decoded_t;

    // execute -> result
    typedef struct packed {
        logic                  valid;
        opcode_t               op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
        logic [xlen-1:0]       product_hi;
    } executed_t;

    // retired instruction report
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } commit_t;

    // register file write port
    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] addr;
        logic [xlen-1:0]       data;
    } rf_write_t;

endpackage

//--- design/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              instr_req_i,
    input  logic [core_pkg::xlen-1:0]         instr_i,
    output logic                              instr_ack_o,
    output logic [core_pkg::reg_addr_w-1:0]   rs_addr_o,
    output logic [core_pkg::reg_addr_w-1:0]   rt_addr_o,
    input  logic [core_pkg::xlen-1:0]         rs_data_i,
    input  logic [core_pkg::xlen-1:0]         rt_data_i,
    output core_pkg::decoded_t                dec_o
);

    logic                            ack_q;
    logic                            accept;
    logic [5:0]                      opc;
    logic [5:0]                      funct;
    logic [core_pkg::imm_w-1:0]      imm;
    core_pkg::opcode_t               op;
    core_pkg::decoded_t              dec_d;
    core_pkg::decoded_t              dec_q;

    // instruction fields
    assign opc   = instr_i[31:26];
    assign funct = instr_i[5:0];
    assign imm   = instr_i[core_pkg::imm_w-1:0];

    // register file read straight off the incoming word
    assign rs_addr_o = instr_i[25:21];
    assign rt_addr_o = instr_i[20:16];

    // accept edge: req seen while ack still low
    assign accept = instr_req_i && !ack_q;

    // opcode / function field to internal op
    always_comb begin
        op = core_pkg::op_nop;
        case (opc)
            core_pkg::opc_special: begin
                case (funct)
                    core_pkg::fn_addu:  op = core_pkg::op_addu;
                    core_pkg::fn_subu:  op = core_pkg::op_subu;
                    core_pkg::fn_and:   op = core_pkg::op_and;
                    core_pkg::fn_or:    op = core_pkg::op_or;
                    core_pkg::fn_xor:   op = core_pkg::op_xor;
                    core_pkg::fn_slt:   op = core_pkg::op_slt;
                    core_pkg::fn_sll:   op = core_pkg::op_sll;
                    core_pkg::fn_srl:   op = core_pkg::op_srl;
                    core_pkg::fn_multu: op = core_pkg::op_multu;
                    core_pkg::fn_mfhi:  op = core_pkg::op_mfhi;
                    core_pkg::fn_mflo:  op = core_pkg::op_mflo;
                    default:            op = core_pkg::op_nop;
                endcase
            end
            core_pkg::opc_addiu: op = core_pkg::op_addiu;
            core_pkg::opc_ori:   op = core_pkg::op_ori;
            core_pkg::opc_lui:   op = core_pkg::op_lui;
            default:             op = core_pkg::op_nop;
        endcase
    end

    // operand and destination selection
    always_comb begin
        dec_d.valid = 1'b1;
        dec_d.op    = op;
        dec_d.rd    = instr_i[15:11];
        dec_d.src_a = rs_data_i;
        dec_d.src_b = rt_data_i;
        dec_d.shamt = instr_i[10:6];
        case (op)
            // immediate forms target rt
            core_pkg::op_addiu: begin
                dec_d.src_b = {{(core_pkg::xlen-core_pkg::imm_w){imm[core_pkg::imm_w-1]}}, imm};
                dec_d.rd    = rt_addr_o;
            end
            core_pkg::op_ori: begin
                dec_d.src_b = {{(core_pkg::xlen-core_pkg::imm_w){1'b0}}, imm};
                dec_d.rd    = rt_addr_o;
            end
            core_pkg::op_lui: begin
                dec_d.src_b = {imm, {(core_pkg::xlen-core_pkg::imm_w){1'b0}}};
                dec_d.rd    = rt_addr_o;
            end
            // no gpr destination
            core_pkg::op_multu, core_pkg::op_nop: dec_d.rd = '0;
            default: ;
        endcase
    end

    // four-phase ack, drops once req is seen low
    always_ff @(posedge clk) begin
        if (reset) begin
            ack_q <= 1'b0;
        end else if (accept) begin
            ack_q <= 1'b1;
        end else if (!instr_req_i) begin
            ack_q <= 1'b0;
        end
    end

    // stage register, valid for the cycle after accept only
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_q.valid <= 1'b0;
        end else if (accept) begin
            dec_q <= dec_d;
        end else begin
            dec_q.valid <= 1'b0;
        end
    end

    assign instr_ack_o = ack_q;
    assign dec_o       = dec_q;

endmodule

//--- design/mips_lite_core.sv
`timescale 1ns/1ps

module mips_lite_core (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      instr_req_i,
    input  logic [core_pkg::xlen-1:0] instr_i,
    output logic                      instr_ack_o,
    output core_pkg::commit_t         commit_o
);

    // decode <-> register file
    logic [core_pkg::reg_addr_w-1:0] rs_addr;
    logic [core_pkg::reg_addr_w-1:0] rt_addr;
    logic [core_pkg::xlen-1:0]       rs_data;
    logic [core_pkg::xlen-1:0]       rt_data;

    // stage to stage
    core_pkg::decoded_t              dec;
    core_pkg::executed_t             exe;
    core_pkg::rf_write_t             rf_wr;

    instr_decode u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_req_i (instr_req_i),
        .instr_i     (instr_i),
        .instr_ack_o (instr_ack_o),
        .rs_addr_o   (rs_addr),
        .rt_addr_o   (rt_addr),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .dec_o       (dec)
    );

    regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data),
        .wr_i      (rf_wr)
    );

    alu_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .dec_i (dec),
        .exe_o (exe)
    );

    result_commit u_result (
        .clk      (clk),
        .reset    (reset),
        .exe_i    (exe),
        .rf_wr_o  (rf_wr),
        .commit_o (commit_o)
    );

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [core_pkg::reg_addr_w-1:0] rs_addr_i,
    input  logic [core_pkg::reg_addr_w-1:0] rt_addr_i,
    output logic [core_pkg::xlen-1:0]       rs_data_o,
    output logic [core_pkg::xlen-1:0]       rt_data_o,
    input  core_pkg::rf_write_t             wr_i
);

    logic [core_pkg::xlen-1:0] regs [core_pkg::num_regs];

    // write on the commit edge but never to r0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < core_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.en && (wr_i.addr != '0)) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // async read where r0 keeps its reset zero
    assign rs_data_o = regs[rs_addr_i];
    assign rt_data_o = regs[rt_addr_i];

endmodule

//--- design/result_commit.sv
`timescale 1ns/1ps

module result_commit (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::executed_t  exe_i,
    output core_pkg::rf_write_t  rf_wr_o,
    output core_pkg::commit_t    commit_o
);

    logic [core_pkg::xlen-1:0] hi_q;
    logic [core_pkg::xlen-1:0] lo_q;
    logic [core_pkg::xlen-1:0] wb_data;
    logic                      wb_en;
    logic                      is_multu;
    core_pkg::commit_t         commit_d;
    core_pkg::commit_t         commit_q;

    assign is_multu = exe_i.valid && (exe_i.op == core_pkg::op_multu);

    // hi/lo reads see the last retired multu
    always_comb begin
        case (exe_i.op)
            core_pkg::op_mfhi: wb_data = hi_q;
            core_pkg::op_mflo: wb_data = lo_q;
            default:           wb_data = exe_i.value;
        endcase
    end

    // gpr write for everything but multu and nop, r0 excluded
    assign wb_en = exe_i.valid
                && (exe_i.op != core_pkg::op_multu)
                && (exe_i.op != core_pkg::op_nop)
                && (exe_i.rd != '0);

    // write lands on the same edge the commit is registered
    assign rf_wr_o.en   = wb_en;
    assign rf_wr_o.addr = exe_i.rd;
    assign rf_wr_o.data = wb_en ? wb_data : '0;

    assign commit_d.valid = exe_i.valid;
    assign commit_d.write = wb_en;
    assign commit_d.rd    = exe_i.rd;
    assign commit_d.data  = wb_en ? wb_data : '0;

    // hi/lo pair
    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else if (is_multu) begin
            hi_q <= exe_i.product_hi;
            lo_q <= exe_i.value;
        end
    end

    // commit port, single-cycle pulse per instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            commit_q.valid <= 1'b0;
        end else begin
            commit_q <= commit_d;
        end
    end

    assign commit_o = commit_q;

endmodule

//--- verification/core_sva.sv
`timescale 1ns/1ps

module core_sva (
    input logic clk,
    input logic reset,
    input logic instr_req_i,
    input logic instr_ack_o,
    input logic commit_valid_i
);

    // ack only rises after an edge that saw req high
    ack_rise_with_req: assert property (@(posedge clk) disable iff (reset)
        $rose(instr_ack_o) |-> $past(instr_req_i))
        else $error("instr_ack_o rose without instr_req_i");

    // ack only falls after an edge that saw req low
    ack_fall_without_req: assert property (@(posedge clk) disable iff (reset)
        $fell(instr_ack_o) |-> !$past(instr_req_i))
        else $error("instr_ack_o fell while instr_req_i was high");

    // one-cycle commit pulse
    commit_single_cycle: assert property (@(posedge clk) disable iff (reset)
        commit_valid_i |=> !commit_valid_i)
        else $error("commit valid held for two cycles");

endmodule

bind mips_lite_core core_sva u_core_sva (
    .clk            (clk),
    .reset          (reset),
    .instr_req_i    (instr_req_i),
    .instr_ack_o    (instr_ack_o),
    .commit_valid_i (commit_o.valid)
);

//--- verification/tb_core.sv
`timescale 1ns/1ps

module tb_core;

    // 34 directed words plus the random stream
    localparam int num_random  = 300;
    localparam int num_instrs  = 34 + num_random;
    localparam int cycle_limit = 8 * num_instrs + 100;

    logic                  clk;
    logic                  reset;
    logic                  instr_req_i;
    logic [31:0]           instr_i;
    logic                  instr_ack_o;
    core_pkg::commit_t     commit_o;

    logic [31:0]           model_regs [32];
    logic [31:0]           model_hi;
    logic [31:0]           model_lo;
    logic [31:0]           lfsr_state;
    core_pkg::commit_t     exp_q [$];
    string                 name_q [$];
    string                 test_name;
    int                    errors;
    int                    checks;
    int                    cycle_count;

    mips_lite_core dut0 (
        .clk         (clk),
        .reset       (reset),
        .instr_req_i (instr_req_i),
        .instr_i     (instr_i),
        .instr_ack_o (instr_ack_o),
        .commit_o    (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] r_type(input int rs, input int rt, input int rd,
                                           input int sh, input logic [5:0] fn);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] opc, input int rs, input int rt,
                                           input logic [15:0] imm);
        return {opc, rs[4:0], rt[4:0], imm};
    endfunction

    // architectural model of one instruction returning the expected commit
    function automatic core_pkg::commit_t ref_execute(input logic [31:0] w);
        core_pkg::commit_t c;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] prod;
        logic        wr;
        logic [4:0]  dst;
        logic [31:0] val;
        a   = model_regs[w[25:21]];
        b   = model_regs[w[20:16]];
        wr  = 1'b1;
        dst = w[15:11];
        val = '0;
        case (w[31:26])
            6'h00: begin
                case (w[5:0])
                    6'h21: val = a + b;
                    6'h23: val = a - b;
                    6'h24: val = a & b;
                    6'h25: val = a | b;
                    6'h26: val = a ^ b;
                    6'h2a: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h00: val = b << w[10:6];
                    6'h02: val = b >> w[10:6];
                    6'h10: val = model_hi;
                    6'h12: val = model_lo;
                    6'h19: begin
                        prod = {32'd0, a} * {32'd0, b};
                        model_hi = prod[63:32];
                        model_lo = prod[31:0];
                        wr  = 1'b0;
                        dst = '0;
                    end
                    default: begin
                        wr  = 1'b0;
                        dst = '0;
                    end
                endcase
            end
            // immediates target rt
            6'h09: begin
                val = a + {{16{w[15]}}, w[15:0]};
                dst = w[20:16];
            end
            6'h0d: begin
                val = a | {16'd0, w[15:0]};
                dst = w[20:16];
            end
            6'h0f: begin
                val = {w[15:0], 16'd0};
                dst = w[20:16];
            end
            default: begin
                wr  = 1'b0;
                dst = '0;
            end
        endcase
        if (dst == 5'd0) begin
            wr = 1'b0;
        end
        if (wr) begin
            model_regs[dst] = val;
        end
        c.valid = 1'b1;
        c.write = wr;
        c.rd    = dst;
        c.data  = wr ? val : 32'd0;
        return c;
    endfunction

    // four-phase transfer then one idle cycle so the previous write has landed
    task automatic send_instr(input logic [31:0] w, input int gap);
        repeat (gap) @(negedge clk);
        exp_q.push_back(ref_execute(w));
        name_q.push_back(test_name);
        instr_i     = w;
        instr_req_i = 1'b1;
        @(negedge clk);
        while (!instr_ack_o) @(negedge clk);
        instr_req_i = 1'b0;
        @(negedge clk);
        while (instr_ack_o) @(negedge clk);
        @(negedge clk);
    endtask

    function automatic logic [31:0] random_instr();
        int sel;
        int rs;
        int rt;
        int rd;
        int sh;
        logic [15:0] imm;
        sel = rand_bits(4) % 14;
        rs  = rand_bits(3);
        rt  = rand_bits(3);
        rd  = rand_bits(3);
        sh  = rand_bits(5);
        imm = rand_bits(16);
        case (sel)
            0:  return r_type(rs, rt, rd, 0, core_pkg::fn_addu);
            1:  return r_type(rs, rt, rd, 0, core_pkg::fn_subu);
            2:  return r_type(rs, rt, rd, 0, core_pkg::fn_and);
            3:  return r_type(rs, rt, rd, 0, core_pkg::fn_or);
            4:  return r_type(rs, rt, rd, 0, core_pkg::fn_xor);
            5:  return r_type(rs, rt, rd, 0, core_pkg::fn_slt);
            6:  return r_type(0, rt, rd, sh, core_pkg::fn_sll);
            7:  return r_type(0, rt, rd, sh, core_pkg::fn_srl);
            8:  return i_type(core_pkg::opc_addiu, rs, rt, imm);
            9:  return i_type(core_pkg::opc_ori, rs, rt, imm);
            10: return i_type(core_pkg::opc_lui, 0, rt, imm);
            11: return r_type(rs, rt, 0, 0, core_pkg::fn_multu);
            12: return r_type(0, 0, rd, 0, core_pkg::fn_mfhi);
            default: return r_type(0, 0, rd, 0, core_pkg::fn_mflo);
        endcase
    endfunction

    // compare each commit against the next expected entry
    always @(negedge clk) begin
        core_pkg::commit_t exp;
        string nm;
        if (!reset && commit_o.valid) begin
            checks++;
            if (exp_q.size() == 0) begin
                $display("commit seen with no instruction outstanding");
                errors++;
            end else begin
                exp = exp_q.pop_front();
                nm  = name_q.pop_front();
                if (commit_o !== exp) begin
                    $display("[ERROR] %s: expected %h actual %h", nm, exp, commit_o);
                    errors++;
                end
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: commits stopped arriving before the run finished");
            errors++;
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        instr_req_i = 1'b0;
        instr_i     = '0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        lfsr_state  = 32'h752b0a4f;
        model_hi    = '0;
        model_lo    = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) @(negedge clk);
        reset = 1'b0;
        if (instr_ack_o !== 1'b0 || commit_o.valid !== 1'b0) begin
            $display("ack or commit valid not low after reset");
            errors++;
        end

        // seed then every alu op with slt on mixed signs
        test_name = "alu_directed";
        send_instr(i_type(core_pkg::opc_lui, 0, 1, 16'h8000), 0);
        send_instr(i_type(core_pkg::opc_ori, 1, 1, 16'h1234), 0);
        send_instr(i_type(core_pkg::opc_ori, 0, 2, 16'h00ff), 0);
        send_instr(i_type(core_pkg::opc_lui, 0, 3, 16'h7fff), 0);
        send_instr(i_type(core_pkg::opc_ori, 3, 3, 16'hfff0), 0);
        send_instr(r_type(1, 3, 4, 0, core_pkg::fn_addu), 1);
        send_instr(r_type(2, 1, 5, 0, core_pkg::fn_subu), 0);
        send_instr(r_type(1, 3, 6, 0, core_pkg::fn_and), 2);
        send_instr(r_type(1, 2, 7, 0, core_pkg::fn_or), 0);
        send_instr(r_type(1, 3, 4, 0, core_pkg::fn_xor), 0);
        send_instr(r_type(1, 2, 5, 0, core_pkg::fn_slt), 0);
        send_instr(r_type(2, 1, 6, 0, core_pkg::fn_slt), 0);
        send_instr(r_type(0, 1, 7, 4, core_pkg::fn_sll), 0);
        send_instr(r_type(0, 1, 4, 8, core_pkg::fn_srl), 0);

        // dependent addiu chain at full rate
        test_name = "addiu_chain";
        send_instr(i_type(core_pkg::opc_addiu, 0, 1, 16'd5), 0);
        send_instr(i_type(core_pkg::opc_addiu, 1, 1, 16'hfffd), 0);
        send_instr(i_type(core_pkg::opc_addiu, 1, 1, 16'h7fff), 0);
        send_instr(i_type(core_pkg::opc_addiu, 1, 1, 16'h8000), 0);
        send_instr(i_type(core_pkg::opc_addiu, 1, 1, 16'd100), 0);
        send_instr(i_type(core_pkg::opc_addiu, 1, 1, 16'hffff), 0);
        send_instr(i_type(core_pkg::opc_addiu, 1, 2, 16'd1), 0);
        send_instr(i_type(core_pkg::opc_addiu, 2, 2, 16'd2), 0);

        test_name = "hilo";
        // hi still holds its reset value here
        send_instr(r_type(0, 0, 4, 0, core_pkg::fn_mfhi), 0);
        send_instr(i_type(core_pkg::opc_lui, 0, 2, 16'hffff), 0);
        send_instr(i_type(core_pkg::opc_ori, 2, 2, 16'hfffe), 0);
        send_instr(i_type(core_pkg::opc_lui, 0, 3, 16'hdead), 0);
        send_instr(i_type(core_pkg::opc_ori, 3, 3, 16'hbeef), 0);
        send_instr(r_type(2, 3, 0, 0, core_pkg::fn_multu), 0);
        send_instr(r_type(0, 0, 4, 0, core_pkg::fn_mfhi), 0);
        send_instr(r_type(0, 0, 5, 0, core_pkg::fn_mflo), 0);

        // r0 write, r0 read, two unsupported encodings
        test_name = "r0_and_nop";
        send_instr(i_type(core_pkg::opc_addiu, 0, 0, 16'h0055), 0);
        send_instr(r_type(0, 0, 6, 0, core_pkg::fn_addu), 0);
        send_instr(32'hfc00_0000, 0);
        send_instr(r_type(1, 2, 3, 0, 6'h3f), 0);

        test_name = "random";
        for (int n = 0; n < num_random; n++) begin
            logic [31:0] w;
            int gap;
            w   = random_instr();
            gap = rand_bits(2);
            send_instr(w, gap);
        end

        // wait for the last commits to drain
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/core_pkg.sv
design/regfile.sv
design/instr_decode.sv
design/alu_execute.sv
design/result_commit.sv
design/mips_lite_core.sv
verification/core_sva.sv
verification/tb_core.sv
